/* all.f */
+incdir+hdl
hdl/duel_pkg.sv
hdl/button_sync.sv
hdl/press_arbiter.sv
hdl/duel_fsm.sv
hdl/hextext_handler.sv
hdl/duel_top.sv
dv/duel_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the duel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module duel_tb -o duel_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/duel_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* dv/duel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module duel_tb;
  import duel_pkg::*;

  localparam int TICK_DIV   = 16;
  localparam int NONE       = -1; // No press in this round
  localparam int RND        = -2; // Delay drawn from the xorshift sequence
  localparam int NUM_ROWS   = 11;
  localparam int ROW_CYCLES = 110 * TICK_DIV + 50; // Worst case per round
  localparam int IDLE_WAIT  = 20;

  typedef struct packed {
    logic       two_player;
    logic       debug;
    int         p1; // Press delay in ticks after FIGHT
    int         p2;
    hex_state_t state;
    int         dur;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b0, 1'b0, 5,    NONE, HEX_P1_WIN, 5},
    '{1'b0, 1'b0, 0,    NONE, HEX_P1_WIN, 0},
    '{1'b1, 1'b0, NONE, 12,   HEX_P2_WIN, 12},
    '{1'b1, 1'b0, 37,   37,   HEX_EQ,     37}, // Same-cycle tie
    '{1'b0, 1'b0, 20,   8,    HEX_P1_WIN, 20}, // P2 masked in 1P
    '{1'b0, 1'b0, NONE, 15,   HEX_EQ,     99},
    '{1'b1, 1'b0, NONE, NONE, HEX_EQ,     99},
    '{1'b1, 1'b1, 40,   52,   HEX_P1_WIN, 40}, // Later P2 press is ignored
    '{1'b1, 1'b0, RND,  NONE, HEX_P1_WIN, RND},
    '{1'b1, 1'b0, RND,  RND,  HEX_EQ,     RND},
    '{1'b1, 1'b0, NONE, RND,  HEX_P2_WIN, RND}
  };

  localparam seg_t DIGITS [10] = '{SEG_0, SEG_1, SEG_2, SEG_3, SEG_4,
                                   SEG_5, SEG_6, SEG_7, SEG_8, SEG_9};

  logic        clk;
  logic        rst_n;
  logic        key_start_n;
  logic        key_p1_n;
  logic        key_p2_n;
  logic        sw_two_player;
  logic        sw_debug;
  seg_t        hex0;
  seg_t        hex1;
  seg_t        hex2;
  seg_t        hex3;
  seg_t        hex4;
  seg_t        hex5;
  int          errors;
  int          rounds_ok;
  int          rounds_bad;
  logic [31:0] rng_state;

  duel_top #(.TICK_DIV(TICK_DIV)) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .key_start_n   (key_start_n),
    .key_p1_n      (key_p1_n),
    .key_p2_n      (key_p2_n),
    .sw_two_player (sw_two_player),
    .sw_debug      (sw_debug),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Six-digit word with d5 leftmost
  function automatic hex_bank_t expected_word(input hex_state_t st, input int dur);
    seg_t tens;
    seg_t ones;
    tens = DIGITS[4'(dur / 10)];
    ones = DIGITS[4'(dur % 10)];
    case (st)
      HEX_1P:     return {SEG_1, SEG_P, {4{SEG_SPACE}}};
      HEX_2P:     return {SEG_2, SEG_P, {4{SEG_SPACE}}};
      HEX_FIGHT:  return {SEG_F, SEG_I, SEG_G, SEG_H, SEG_T, SEG_SPACE};
      HEX_P1_WIN: return {SEG_P, SEG_1, SEG_DASH, tens, ones, SEG_DASH};
      HEX_P2_WIN: return {SEG_P, SEG_2, SEG_DASH, tens, ones, SEG_DASH};
      HEX_EQ:     return {SEG_E, SEG_Q, SEG_DASH, tens, ones, SEG_DASH};
      default:    return {{4{SEG_SPACE}}, tens, ones};
    endcase
  endfunction

  function automatic hex_bank_t shown();
    return {hex5, hex4, hex3, hex2, hex1, hex0};
  endfunction

  // Cycles after FIGHT so the press lands mid-tick
  function automatic int press_cycle(input int ticks);
    return (ticks < 0) ? NONE : TICK_DIV * ticks + TICK_DIV / 2;
  endfunction

  task automatic check(input string name, input seg_t got, input seg_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_display(input hex_bank_t exp);
    hex_bank_t got;
    got = shown();
    check("hex5", got.d5, exp.d5);
    check("hex4", got.d4, exp.d4);
    check("hex3", got.d3, exp.d3);
    check("hex2", got.d2, exp.d2);
    check("hex1", got.d1, exp.d1);
    check("hex0", got.d0, exp.d0);
  endtask

  task automatic report_failure(input int idx, input string what);
    errors++;
    $display("Round %0d: %s", idx, what);
  endtask

  task automatic wait_display(input hex_bank_t exp, input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = (shown() === exp);
      n++;
    end
  endtask

  // Every result word has dashes on hex3 and hex0
  task automatic wait_result(input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
      @(negedge clk);
      seen = (hex3 === SEG_DASH) && (hex0 === SEG_DASH);
      n++;
    end
  endtask

  task automatic press_start();
    @(posedge clk);
    key_start_n <= 1'b0;
    repeat (3) @(posedge clk);
    key_start_n <= 1'b1;
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   d;
    int   t1;
    int   t2;
    int   tp;
    int   t_end;
    int   dur;
    int   c;
    int   errs_before;
    bit   seen;
    r = ROWS[idx];
    errs_before = errors;
    rng_state = xorshift(rng_state);
    d = int'(rng_state % 32'd90) + 1;
    t1 = press_cycle((r.p1 == RND) ? d : r.p1);
    t2 = press_cycle((r.p2 == RND) ? d : r.p2);
    dur = (r.dur == RND) ? d : r.dur;
    tp = r.debug ? press_cycle(dur / 2) : NONE; // Live duration probe
    t_end = 1;
    if (t1 > t_end) t_end = t1;
    if (t2 > t_end) t_end = t2;
    if (tp > t_end) t_end = tp;

    @(posedge clk);
    sw_two_player <= r.two_player;
    sw_debug      <= 1'b0;
    wait_display(expected_word(r.two_player ? HEX_2P : HEX_1P, 0), IDLE_WAIT, seen);
    if (!seen) begin
      report_failure(idx, "idle display did not show the player mode");
    end

    press_start();
    wait_display(expected_word(HEX_FIGHT, 0), IDLE_WAIT, seen);
    if (!seen) begin
      report_failure(idx, "start press did not bring up the FIGHT display");
    end else begin
      for (c = 1; c <= t_end; c++) begin
        @(posedge clk);
        if (c == 1) sw_debug <= r.debug;
        if (c == t1) key_p1_n <= 1'b0;
        if (c == t2) key_p2_n <= 1'b0;
        if (c == tp) begin
          @(negedge clk);
          check_display(expected_word(HEX_DEBUG, dur / 2));
        end
      end
      wait_result(ROW_CYCLES, seen);
      if (!seen) begin
        report_failure(idx, "no result display appeared before the round limit");
      end else begin
        check_display(expected_word(r.state, dur));
      end
    end

    @(posedge clk);
    key_p1_n <= 1'b1;
    key_p2_n <= 1'b1;
    sw_debug <= 1'b0;
    press_start(); // Back to idle

    if (errors == errs_before) begin
      rounds_ok++;
      $display("Round %0d: %0dP, state %0d, duration %0d passed",
               idx, r.two_player ? 2 : 1, r.state, dur);
    end else begin
      rounds_bad++;
      $display("Round %0d: %0dP, state %0d, duration %0d failed",
               idx, r.two_player ? 2 : 1, r.state, dur);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    key_start_n   = 1'b1;
    key_p1_n      = 1'b1;
    key_p2_n      = 1'b1;
    sw_two_player = 1'b0;
    sw_debug      = 1'b0;
    errors        = 0;
    rounds_ok     = 0;
    rounds_bad    = 0;
    rng_state     = 32'd93881;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    $display("Rounds passed: %0d, failed: %0d, check errors: %0d",
             rounds_ok, rounds_bad, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * ROW_CYCLES + 200) @(posedge clk);
    $display("Watchdog: the run exceeded its cycle limit and was stopped");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/duel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module duel_top #(
  parameter int unsigned TICK_DIV = duel_pkg::TICK_DIV_BOARD
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           key_start_n,
  input  logic           key_p1_n,
  input  logic           key_p2_n,
  input  logic           sw_two_player,
  input  logic           sw_debug,
  output duel_pkg::seg_t hex0,
  output duel_pkg::seg_t hex1,
  output duel_pkg::seg_t hex2,
  output duel_pkg::seg_t hex3,
  output duel_pkg::seg_t hex4,
  output duel_pkg::seg_t hex5
);
  import duel_pkg::*;

  logic       start_press;
  logic       p1_press;
  logic       p2_press;
  logic       armed;
  grant_t     grant;
  hex_state_t hex_state;
  duration_t  duration;
  hex_bank_t  hex;

  button_sync u_sync_start (
    .clk(clk), .rst_n(rst_n), .key_n(key_start_n), .press(start_press)
  );
  button_sync u_sync_p1 (
    .clk(clk), .rst_n(rst_n), .key_n(key_p1_n), .press(p1_press)
  );
  button_sync u_sync_p2 (
    .clk(clk), .rst_n(rst_n), .key_n(key_p2_n), .press(p2_press)
  );

  press_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .armed      (armed),
    .two_player (sw_two_player),
    .p1_press   (p1_press),
    .p2_press   (p2_press),
    .grant      (grant)
  );

  duel_fsm #(.TICK_DIV(TICK_DIV)) u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start_press),
    .two_player (sw_two_player),
    .debug      (sw_debug),
    .grant      (grant),
    .armed      (armed),
    .hex_state  (hex_state),
    .duration   (duration)
  );

  hextext_handler u_text (
    .hex_state (hex_state),
    .duration  (duration),
    .hex       (hex)
  );

  assign hex5 = hex.d5; // Leftmost
  assign hex4 = hex.d4;
  assign hex3 = hex.d3;
  assign hex2 = hex.d2;
  assign hex1 = hex.d1;
  assign hex0 = hex.d0;

endmodule

`default_nettype wire

/* hdl/hextext_handler.sv */
`timescale 1ns/1ps
`default_nettype none

module hextext_handler (
  input  duel_pkg::hex_state_t hex_state,
  input  duel_pkg::duration_t  duration,
  output duel_pkg::hex_bank_t  hex
);
  import duel_pkg::*;

  logic [6:0] tens;
  logic [6:0] ones;
  seg_t       seg_tens;
  seg_t       seg_ones;

  function automatic seg_t to_seg(input logic [6:0] value);
    case (value)
      7'd0:    to_seg = SEG_0;
      7'd1:    to_seg = SEG_1;
      7'd2:    to_seg = SEG_2;
      7'd3:    to_seg = SEG_3;
      7'd4:    to_seg = SEG_4;
      7'd5:    to_seg = SEG_5;
      7'd6:    to_seg = SEG_6;
      7'd7:    to_seg = SEG_7;
      7'd8:    to_seg = SEG_8;
      7'd9:    to_seg = SEG_9;
      default: to_seg = SEG_SPACE; // Out of range
    endcase
  endfunction

  assign tens     = duration / 7'd10;
  assign ones     = duration % 7'd10;
  assign seg_tens = to_seg(tens);
  assign seg_ones = to_seg(ones);

  always_comb begin
    case (hex_state)
      HEX_1P: begin
        hex = {SEG_1, SEG_P, SEG_SPACE, SEG_SPACE, SEG_SPACE, SEG_SPACE};
      end
      HEX_2P: begin
        hex = {SEG_2, SEG_P, SEG_SPACE, SEG_SPACE, SEG_SPACE, SEG_SPACE};
      end
      HEX_FIGHT: begin
        hex = {SEG_F, SEG_I, SEG_G, SEG_H, SEG_T, SEG_SPACE};
      end
      HEX_P1_WIN: begin
        hex = {SEG_P, SEG_1, SEG_DASH, seg_tens, seg_ones, SEG_DASH};
      end
      HEX_P2_WIN: begin
        hex = {SEG_P, SEG_2, SEG_DASH, seg_tens, seg_ones, SEG_DASH};
      end
      HEX_EQ: begin
        hex = {SEG_E, SEG_Q, SEG_DASH, seg_tens, seg_ones, SEG_DASH};
      end
      default: begin
        // Debug view with the live duration on the two rightmost digits
        hex.d5 = SEG_SPACE;
        hex.d4 = SEG_SPACE;
        hex.d3 = SEG_SPACE;
        hex.d2 = SEG_SPACE;
        hex.d1 = seg_tens;
        hex.d0 = seg_ones;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/duel_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module duel_fsm #(
  parameter int unsigned TICK_DIV = duel_pkg::TICK_DIV_BOARD
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 two_player,
  input  logic                 debug,
  input  duel_pkg::grant_t     grant,
  output logic                 armed,
  output duel_pkg::hex_state_t hex_state,
  output duel_pkg::duration_t  duration
);
  import duel_pkg::*;

  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0,
    PH_FIGHT  = 2'd1,
    PH_RESULT = 2'd2
  } phase_t;

  phase_t    phase_q;
  verdict_t  verdict_q;
  logic [31:0] tick_q;
  duration_t duration_q;
  logic      tick;
  logic      timeout;

  assign tick     = (tick_q == 32'(TICK_DIV - 1));
  assign timeout  = (duration_q == DURATION_MAX);
  assign armed    = (phase_q == PH_FIGHT);
  assign duration = duration_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q    <= PH_IDLE;
      verdict_q  <= VERDICT_NONE;
      tick_q     <= '0;
      duration_q <= '0;
    end else begin
      case (phase_q)
        PH_IDLE: begin
          if (start) begin
            phase_q    <= PH_FIGHT;
            tick_q     <= '0; // Fresh round
            duration_q <= '0;
          end
        end
        PH_FIGHT: begin
          if (grant.valid) begin
            phase_q   <= PH_RESULT; // Duration freezes here
            verdict_q <= grant.verdict;
          end else if (timeout) begin
            phase_q   <= PH_RESULT;
            verdict_q <= VERDICT_TIE;
          end else if (tick) begin
            tick_q     <= '0;
            duration_q <= duration_q + 7'd1;
          end else begin
            tick_q <= tick_q + 32'd1;
          end
        end
        PH_RESULT: begin
          if (start) begin
            phase_q <= PH_IDLE;
          end
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  // Debug only overrides the idle and fight displays
  always_comb begin
    case (phase_q)
      PH_IDLE: begin
        if (debug)           hex_state = HEX_DEBUG;
        else if (two_player) hex_state = HEX_2P;
        else                 hex_state = HEX_1P;
      end
      PH_FIGHT: begin
        hex_state = debug ? HEX_DEBUG : HEX_FIGHT;
      end
      PH_RESULT: begin
        case (verdict_q)
          VERDICT_P1: hex_state = HEX_P1_WIN;
          VERDICT_P2: hex_state = HEX_P2_WIN;
          default:    hex_state = HEX_EQ;
        endcase
      end
      default: hex_state = HEX_1P;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/press_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module press_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            armed,
  input  logic            two_player,
  input  logic            p1_press,
  input  logic            p2_press,
  output duel_pkg::grant_t grant
);
  import duel_pkg::*;

  logic p2_live;
  logic done_q;

  assign p2_live = two_player & p2_press; // P2 masked in 1P mode

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant  <= '0;
      done_q <= 1'b0;
    end else begin
      grant.valid <= 1'b0;
      if (!armed) begin
        done_q <= 1'b0; // Rearm for next round
      end else if (!done_q && (p1_press || p2_live)) begin
        grant.valid <= 1'b1;
        done_q      <= 1'b1;
        case ({p1_press, p2_live})
          2'b11:   grant.verdict <= VERDICT_TIE;
          2'b10:   grant.verdict <= VERDICT_P1;
          default: grant.verdict <= VERDICT_P2;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/button_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module button_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic key_n,
  output logic press
);

  logic [1:0] sync_q;
  logic       held_q;
  logic       pressed;

  assign pressed = ~sync_q[1]; // Key is active low

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b11; // Released
      held_q <= 1'b0;
      press  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], key_n};
      held_q <= pressed;
      press  <= pressed & ~held_q; // One pulse per press
    end
  end

endmodule

`default_nettype wire

/* hdl/duel_pkg.sv */
`default_nettype none

package duel_pkg;

  typedef logic [6:0] seg_t;
  typedef logic [6:0] duration_t;

  localparam duration_t   DURATION_MAX   = 7'd99; // Saturation value in tenths
  localparam int unsigned TICK_DIV_BOARD = 5000000; // 10 Hz at 50 MHz

  typedef enum logic [2:0] {
    HEX_1P     = 3'd0,
    HEX_2P     = 3'd1,
    HEX_FIGHT  = 3'd2,
    HEX_P1_WIN = 3'd3,
    HEX_P2_WIN = 3'd4,
    HEX_EQ     = 3'd5,
    HEX_DEBUG  = 3'd6
  } hex_state_t;

  typedef enum logic [1:0] {
    VERDICT_NONE = 2'd0,
    VERDICT_P1   = 2'd1,
    VERDICT_P2   = 2'd2,
    VERDICT_TIE  = 2'd3
  } verdict_t;

  typedef struct packed {
    logic     valid;
    verdict_t verdict;
  } grant_t;

  `include "charto7seg.svh"

  typedef struct packed {
    seg_t d5; // Leftmost digit
    seg_t d4;
    seg_t d3;
    seg_t d2;
    seg_t d1;
    seg_t d0;
  } hex_bank_t;

endpackage

`default_nettype wire

/* hdl/charto7seg.svh */
`ifndef CHARTO7SEG_SVH
`define CHARTO7SEG_SVH

// Active-low patterns in gfedcba bit order
localparam seg_t SEG_0     = 7'b1000000;
localparam seg_t SEG_1     = 7'b1111001;
localparam seg_t SEG_2     = 7'b0100100;
localparam seg_t SEG_3     = 7'b0110000;
localparam seg_t SEG_4     = 7'b0011001;
localparam seg_t SEG_5     = 7'b0010010;
localparam seg_t SEG_6     = 7'b0000010;
localparam seg_t SEG_7     = 7'b1111000;
localparam seg_t SEG_8     = 7'b0000000;
localparam seg_t SEG_9     = 7'b0010000;

localparam seg_t SEG_P     = 7'b0001100;
localparam seg_t SEG_F     = 7'b0001110;
localparam seg_t SEG_I     = 7'b1001111; // Left-hand bar
localparam seg_t SEG_G     = 7'b1000010;
localparam seg_t SEG_H     = 7'b0001001;
localparam seg_t SEG_T     = 7'b0000111; // Lower-case t
localparam seg_t SEG_E     = 7'b0000110;
localparam seg_t SEG_Q     = 7'b0011000; // Lower-case q

localparam seg_t SEG_DASH  = 7'b0111111;
localparam seg_t SEG_SPACE = 7'b1111111;

`endif
